//--- tb.f
src/forth_mem_pkg.sv
src/forth_dict_pkg.sv
src/dict_ram.sv
src/word_finder.sv
src/forth_finder_top.sv
verification/finder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the word finder testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module finder_tb -o finder_sim \
    && ./obj_dir/finder_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- verification/finder_tb.sv
// word finder testbench
// loads a five word dictionary and tib strings and checks every search by assertion

`timescale 1ns/1ps

module finder_tb;

    localparam int addr_w        = forth_mem_pkg::ADDR_WIDTH_DEF;
    localparam int clk_half      = 50;
    localparam int reset_cycles  = 10;
    localparam int search_cycles = 2000;                // bound on one search
    localparam int n_fixed       = 10;
    localparam int n_random      = 30;
    localparam int max_searches  = n_fixed + n_random;
    localparam int watchdog_ns   = max_searches * search_cycles * 2 * clk_half;
    localparam int dict_base     = 'h0100;
    localparam int tib_low       = 'h0800;
    localparam int tib_high      = 'h1_0800;            // above the 16 bit link range

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  load_we;
    logic [addr_w-1:0]     load_addr;
    forth_mem_pkg::byte_t  load_data;
    logic                  en;
    logic [addr_w-1:0]     ctx;
    logic [addr_w-1:0]     tib_addr;
    logic                  bsy;
    logic                  hit;
    logic [addr_w-1:0]     tib_next;

    forth_mem_pkg::byte_t  model [forth_mem_pkg::RAM_DEPTH_DEF];   // copy of loaded bytes
    logic                  exp_hit;                     // reference result set before en
    logic [addr_w-1:0]     exp_next;
    int unsigned           newest;                      // head of the header list
    int                    value_errors;
    int                    timeouts;
    int                    searches;

    logic                  searched;                    // en seen high at least once
    logic                  result_seen;                 // bsy fell in this en pulse
    logic                  bsy_q;
    int                    bsy_cycles;

    string fixed_text [0:n_fixed-1] = '{"DUP", "+ 1", "  SWAP DUP", "OVER", "DROP  X",
                                        "DU", "DROPX", "FOO BAR", "    ", ""};
    string pool [0:11] = '{"DUP", "DROP", "SWAP", "OVER", "+", "DU",
                           "DROPX", "SWA", "OVERX", "+1", "NOP", "DUPE"};

    forth_finder_top #(
        .addr_width (addr_w),
        .ram_depth  (forth_mem_pkg::RAM_DEPTH_DEF)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .en         (en),
        .ctx        (ctx),
        .tib_addr   (tib_addr),
        .bsy        (bsy),
        .hit        (hit),
        .tib_next   (tib_next)
    );

    always #(clk_half) clk = ~clk;

    // search tracking for the checks
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            searched    <= 1'b0;
            result_seen <= 1'b0;
            bsy_q       <= 1'b0;
            bsy_cycles  <= 0;
        end else begin
            if (en) begin
                searched <= 1'b1;
            end
            bsy_q       <= bsy;
            result_seen <= en && (result_seen || (bsy_q && !bsy));   // cleared by en low
            bsy_cycles  <= bsy ? bsy_cycles + 1 : 0;
        end
    end

    task automatic log_mismatch(input string what);
        value_errors++;
        $display("[ERROR] %0d ns: %s", $time, what);
    endtask

    a_quiet_after_reset : assert property (@(posedge clk) disable iff (!rst_n)
        !searched |-> (!bsy && !hit && tib_next == '0)
    ) else log_mismatch("bsy, hit or tib_next not zero before the first search");

    a_bsy_rises : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(en) |=> bsy
    ) else log_mismatch("bsy not high one cycle after en");

    a_bsy_once : assert property (@(posedge clk) disable iff (!rst_n)
        (en && result_seen) |-> !bsy
    ) else log_mismatch("bsy rose again after the result");

    a_bsy_bounded : assert property (@(posedge clk) disable iff (!rst_n)
        bsy |-> (bsy_cycles < search_cycles)
    ) else log_mismatch("search longer than the cycle bound");

    a_hit_value : assert property (@(posedge clk) disable iff (!rst_n)
        (en && (result_seen || $fell(bsy))) |-> (hit == exp_hit)
    ) else log_mismatch($sformatf("hit %0b, expected %0b", $sampled(hit), exp_hit));

    a_next_value : assert property (@(posedge clk) disable iff (!rst_n)
        (en && (result_seen || $fell(bsy))) |-> (tib_next == exp_next)
    ) else log_mismatch($sformatf("tib_next %0h, expected %0h", $sampled(tib_next), exp_next));

    a_hit_clears : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(en) |=> !hit
    ) else log_mismatch("hit still high one cycle after en fell");

    a_idle_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        !en |=> !bsy
    ) else log_mismatch("bsy high while en low");

    task automatic next_cycle();
        @(posedge clk);
        #1;                                             // drive just after the edge
    endtask

    task automatic load_byte(input int unsigned a, input forth_mem_pkg::byte_t d);
        load_we   = 1'b1;
        load_addr = addr_w'(a);
        load_data = d;
        model[a]  = d;                                  // keep the copy in step
        next_cycle();
        load_we   = 1'b0;
    endtask

    // link, length and name bytes followed by a two byte gap
    task automatic add_header(input string name, inout int unsigned at,
                              inout int unsigned prev);
        forth_dict_pkg::link_u lk;
        lk.addr = 16'(prev);
        load_byte(at, lk.bytes.lo);
        load_byte(at + 1, lk.bytes.hi);
        load_byte(at + 2, 8'(name.len()));
        for (int i = 0; i < name.len(); i++) begin
            load_byte(at + 3 + i, name[i]);
        end
        prev = at;
        at   = at + 3 + name.len() + 2;
    endtask

    task automatic load_tib(input string text, input int unsigned base);
        for (int i = 0; i < text.len(); i++) begin
            load_byte(base + i, text[i]);
        end
        load_byte(base + text.len(), forth_dict_pkg::CHAR_NUL);    // end of input
    endtask

    // expected outcome from the header and token rules
    function automatic void ref_search(input int unsigned tib, input int unsigned head,
                                       output logic r_hit, output int unsigned r_next);
        int unsigned           p;
        int unsigned           h;
        int unsigned           len;
        logic                  ok;
        logic                  walking;
        forth_dict_pkg::link_u lk;
        p = tib;
        while (model[p] == forth_dict_pkg::CHAR_SPACE) begin
            p++;                                        // leading spaces
        end
        r_hit   = 1'b0;
        r_next  = p;                                    // token start on a miss
        walking = (model[p] != forth_dict_pkg::CHAR_NUL);
        h       = head;
        while (walking) begin
            lk.bytes.lo = model[h];
            lk.bytes.hi = model[h + 1];
            len         = model[h + 2];
            ok          = 1'b1;
            for (int unsigned k = 0; k < len && ok; k++) begin
                ok = (model[h + 3 + k] == model[p + k]);
            end
            if (ok && (model[p + len] == forth_dict_pkg::CHAR_SPACE ||
                       model[p + len] == forth_dict_pkg::CHAR_NUL)) begin
                r_hit   = 1'b1;
                r_next  = p + len + 1;                  // one past the delimiter
                walking = 1'b0;
            end else if (lk.addr == forth_dict_pkg::LINK_END) begin
                walking = 1'b0;                         // oldest entry failed too
            end else begin
                h = lk.addr;
            end
        end
    endfunction

    function automatic string random_text();
        string s;
        s = "";
        repeat ($urandom_range(3, 0)) s = {s, " "};
        if ($urandom_range(7, 0) != 0) begin            // else spaces only
            s = {s, pool[$urandom_range(11, 0)]};
            repeat ($urandom_range(2, 1)) s = {s, " "};
            s = {s, pool[$urandom_range(11, 0)]};
        end
        return s;
    endfunction

    task automatic run_search(input string text, input int unsigned base);
        int          cyc;
        logic        r_hit;
        int unsigned r_next;
        load_tib(text, base);
        ref_search(base, newest, r_hit, r_next);
        exp_hit  = r_hit;
        exp_next = addr_w'(r_next);
        tib_addr = addr_w'(base);
        en       = 1'b1;
        next_cycle();
        cyc = 0;
        while (bsy && cyc < search_cycles) begin
            next_cycle();
            cyc++;
        end
        if (bsy) begin
            $display("search of \"%s\" did not finish within %0d cycles", text, search_cycles);
            timeouts++;
        end
        next_cycle();                                   // result held while en high
        en = 1'b0;
        repeat (3) next_cycle();
        searches++;
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, run stopped", watchdog_ns);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int unsigned at;
        int unsigned prev;
        void'($urandom(32'h0106_afb7));
        rst_n        = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        en           = 1'b0;
        ctx          = '0;
        tib_addr     = '0;
        exp_hit      = 1'b0;
        exp_next     = '0;
        value_errors = 0;
        timeouts     = 0;
        searches     = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) next_cycle();                        // idle window after reset

        at   = dict_base;
        prev = 32'(forth_dict_pkg::LINK_END);           // oldest entry
        add_header("DUP", at, prev);
        add_header("DROP", at, prev);
        add_header("SWAP", at, prev);
        add_header("OVER", at, prev);
        add_header("+", at, prev);
        newest = prev;
        ctx    = addr_w'(newest);

        for (int i = 0; i < n_fixed; i++) begin
            run_search(fixed_text[i], (i % 2 == 0) ? tib_low : tib_high);
        end
        for (int i = 0; i < n_random; i++) begin
            run_search(random_text(), (i % 2 == 0) ? tib_high : tib_low);
        end

        $display("finder_tb: %0d searches, %0d value errors, %0d timeouts",
                 searches, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : finder_tb

//--- src/forth_finder_top.sv
// forth word finder top level
// dictionary and tib ram with the search engine, plain ports

`timescale 1ns/1ps

module forth_finder_top #(
    parameter int addr_width = forth_mem_pkg::ADDR_WIDTH_DEF,
    parameter int ram_depth  = forth_mem_pkg::RAM_DEPTH_DEF
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_we,     // load only while en and bsy low
    input  logic [addr_width-1:0]  load_addr,
    input  forth_mem_pkg::byte_t   load_data,
    input  logic                   en,          // search request level
    input  logic [addr_width-1:0]  ctx,         // newest header address
    input  logic [addr_width-1:0]  tib_addr,
    output logic                   bsy,
    output logic                   hit,
    output logic [addr_width-1:0]  tib_next
);

    logic [addr_width-1:0] rd_addr;             // finder to ram
    forth_mem_pkg::byte_t  rd_data;             // ram to finder, one cycle later

    dict_ram #(
        .addr_width (addr_width),
        .ram_depth  (ram_depth)
    ) ram0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    word_finder #(
        .addr_width (addr_width)
    ) finder0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .ctx        (ctx),
        .tib_addr   (tib_addr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .bsy        (bsy),
        .hit        (hit),
        .tib_next   (tib_next)
    );

endmodule : forth_finder_top

//--- src/word_finder.sv
// dictionary word finder
// skips tib spaces, walks headers newest to oldest and compares names to the token

`timescale 1ns/1ps

module word_finder #(
    parameter int addr_width = forth_mem_pkg::ADDR_WIDTH_DEF
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,          // level, one search per rise
    input  logic [addr_width-1:0]  ctx,         // newest header
    input  logic [addr_width-1:0]  tib_addr,    // parse position
    output logic [addr_width-1:0]  rd_addr,
    input  forth_mem_pkg::byte_t   rd_data,     // byte for last cycle's rd_addr
    output logic                   bsy,
    output logic                   hit,
    output logic [addr_width-1:0]  tib_next     // where parsing continues
);

    forth_dict_pkg::finder_state_e state, next_state;

    logic [addr_width-1:0] hdr;                 // current header base
    logic [addr_width-1:0] tib_ptr;             // tib byte under compare
    logic [addr_width-1:0] tok_start;           // first non-space of token
    logic [addr_width-1:0] name_ptr;            // next name byte
    logic [addr_width-1:0] name_end;            // one past last name byte
    forth_mem_pkg::byte_t  name_byte;           // name byte awaiting its tib byte
    forth_dict_pkg::link_u link;                // link of current header
    logic                  phase;               // 0 name fetch, 1 tib compare

    logic                  is_space;
    logic                  is_nul;
    logic                  byte_eq;             // tib byte equals held name byte
    logic                  name_last;           // compared byte was the final one
    logic                  delim_ok;            // space or nul after the name
    logic                  last_entry;          // no older header left
    logic [addr_width-1:0] link_ext;            // link widened to byte address
    forth_dict_pkg::finder_state_e miss_state;  // where a failed compare goes

    assign is_space   = (rd_data == forth_dict_pkg::CHAR_SPACE);
    assign is_nul     = (rd_data == forth_dict_pkg::CHAR_NUL);
    assign byte_eq    = (rd_data == name_byte);
    assign name_last  = (name_ptr == name_end);
    assign delim_ok   = is_space || is_nul;
    assign last_entry = (link.addr == forth_dict_pkg::LINK_END);
    assign link_ext   = addr_width'(link.addr); // zero extended
    assign miss_state = last_entry ? forth_dict_pkg::ST_DONE : forth_dict_pkg::ST_LINK_LO;

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= forth_dict_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // next state
    always_comb begin
        next_state = state;
        if (!en) begin
            next_state = forth_dict_pkg::ST_IDLE;           // abort or release
        end else begin
            case (state)
                forth_dict_pkg::ST_IDLE:    next_state = forth_dict_pkg::ST_SKIP;
                forth_dict_pkg::ST_SKIP: begin
                    if (is_nul) begin
                        next_state = forth_dict_pkg::ST_DONE;   // input exhausted
                    end else if (!is_space) begin
                        next_state = forth_dict_pkg::ST_LINK_LO;
                    end
                end
                forth_dict_pkg::ST_LINK_LO: next_state = forth_dict_pkg::ST_LINK_HI;
                forth_dict_pkg::ST_LINK_HI: next_state = forth_dict_pkg::ST_LEN;
                forth_dict_pkg::ST_LEN: begin
                    next_state = (rd_data == '0) ? forth_dict_pkg::ST_DELIM
                                                 : forth_dict_pkg::ST_NAME;
                end
                forth_dict_pkg::ST_NAME: begin
                    if (phase && !byte_eq) begin
                        next_state = miss_state;
                    end else if (phase && name_last) begin
                        next_state = forth_dict_pkg::ST_DELIM;
                    end
                end
                forth_dict_pkg::ST_DELIM: begin
                    next_state = delim_ok ? forth_dict_pkg::ST_DONE : miss_state;
                end
                default:                    next_state = state; // done holds
            endcase
        end
    end

    // memory address, data lands in the following state
    always_comb begin
        case (state)
            forth_dict_pkg::ST_IDLE:    rd_addr = tib_addr;         // first tib byte
            forth_dict_pkg::ST_SKIP:    rd_addr = is_space ? tib_ptr + addr_width'(1) : hdr;
            forth_dict_pkg::ST_LINK_LO: rd_addr = hdr + addr_width'(1);
            forth_dict_pkg::ST_LINK_HI: rd_addr = hdr + addr_width'(2);   // length byte
            forth_dict_pkg::ST_LEN:     rd_addr = (rd_data == '0) ? tib_ptr
                                                                  : hdr + addr_width'(3);
            forth_dict_pkg::ST_NAME: begin
                if (!phase) begin
                    rd_addr = tib_ptr;                              // matching tib byte
                end else if (!byte_eq) begin
                    rd_addr = link_ext;                             // older header
                end else if (name_last) begin
                    rd_addr = tib_ptr + addr_width'(1);             // delimiter
                end else begin
                    rd_addr = name_ptr;
                end
            end
            forth_dict_pkg::ST_DELIM:   rd_addr = link_ext;
            default:                    rd_addr = tib_addr;
        endcase
    end

    // search datapath
    always_ff @(posedge clk) begin
        case (state)
            forth_dict_pkg::ST_IDLE: begin
                hdr       <= ctx;
                tib_ptr   <= tib_addr;
                tok_start <= tib_addr;
            end
            forth_dict_pkg::ST_SKIP: begin
                if (is_space) begin
                    tib_ptr <= tib_ptr + addr_width'(1);
                end else begin
                    tok_start <= tib_ptr;                           // token begins here
                end
            end
            forth_dict_pkg::ST_LINK_LO: link.bytes.lo <= rd_data;
            forth_dict_pkg::ST_LINK_HI: link.bytes.hi <= rd_data;
            forth_dict_pkg::ST_LEN: begin
                name_ptr <= hdr + addr_width'(3);
                name_end <= hdr + addr_width'(3) + addr_width'(rd_data);
            end
            forth_dict_pkg::ST_NAME: begin
                if (!phase) begin
                    name_byte <= rd_data;
                    name_ptr  <= name_ptr + addr_width'(1);
                end else if (!byte_eq) begin
                    hdr     <= link_ext;                            // follow link
                    tib_ptr <= tok_start;                           // rewind token
                end else begin
                    tib_ptr <= tib_ptr + addr_width'(1);
                end
            end
            forth_dict_pkg::ST_DELIM: begin
                if (!delim_ok) begin
                    hdr     <= link_ext;                            // prefix only
                    tib_ptr <= tok_start;
                end
            end
            default: ;
        endcase
    end

    // outputs and compare phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bsy      <= 1'b0;
            hit      <= 1'b0;
            tib_next <= '0;
            phase    <= 1'b0;
        end else begin
            bsy   <= (next_state != forth_dict_pkg::ST_IDLE)
                  && (next_state != forth_dict_pkg::ST_DONE);
            phase <= (state == forth_dict_pkg::ST_NAME) ? !phase : 1'b0;
            if (!en) begin
                hit <= 1'b0;                                        // tib_next kept
            end else begin
                case (state)
                    forth_dict_pkg::ST_SKIP: begin
                        if (is_nul) begin
                            hit      <= 1'b0;
                            tib_next <= tib_ptr;                    // at the zero byte
                        end
                    end
                    forth_dict_pkg::ST_NAME: begin
                        if (phase && !byte_eq && last_entry) begin
                            hit      <= 1'b0;
                            tib_next <= tok_start;
                        end
                    end
                    forth_dict_pkg::ST_DELIM: begin
                        if (delim_ok) begin
                            hit      <= 1'b1;
                            tib_next <= tib_ptr + addr_width'(1);   // past delimiter
                        end else if (last_entry) begin
                            hit      <= 1'b0;
                            tib_next <= tok_start;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // a low en always ends the search by the next cycle
    a_bsy_drops : assert property (
        @(posedge clk) disable iff (!rst_n)
        !en |=> !bsy
    ) else $error("word_finder: bsy high after en low");

    // header walk stays inside the 16 bit link range
    a_hdr_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {forth_dict_pkg::ST_LINK_LO, forth_dict_pkg::ST_LINK_HI})
            |-> ((rd_addr >> 16) == '0)
    ) else $error("word_finder: header read at %0h outside link range", rd_addr);

endmodule : word_finder

//--- src/dict_ram.sv
// dictionary and tib ram
// byte wide single clock array, load write port and registered finder read port

`timescale 1ns/1ps

module dict_ram #(
    parameter int addr_width = forth_mem_pkg::ADDR_WIDTH_DEF,
    parameter int ram_depth  = forth_mem_pkg::RAM_DEPTH_DEF
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_we,     // external load strobe
    input  logic [addr_width-1:0]  load_addr,
    input  forth_mem_pkg::byte_t   load_data,
    input  logic [addr_width-1:0]  rd_addr,     // finder read address
    output forth_mem_pkg::byte_t   rd_data      // byte one cycle after rd_addr
);

    forth_mem_pkg::byte_t mem [ram_depth];      // storage, no reset

    logic rd_in_range;                          // read hits backed storage

    assign rd_in_range = (rd_addr < ram_depth);

    // load port
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    // read register, same cycle write returns old byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_in_range) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= '0;                      // unbacked space reads as nul
        end
    end

    // loads must land inside the array sized at the top level
    a_load_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        load_we |-> (load_addr < ram_depth)
    ) else $error("dict_ram: load address %0h beyond ram depth", load_addr);

endmodule : dict_ram

//--- src/forth_dict_pkg.sv
// forth dictionary format package
// header link layout, link end marker, delimiters and finder states

package forth_dict_pkg;

    // header link, built from two byte reads then used as an address
    typedef union packed {
        struct packed {
            forth_mem_pkg::byte_t hi;   // link high byte, second in memory
            forth_mem_pkg::byte_t lo;   // link low byte, first in memory
        } bytes;
        logic [15:0] addr;              // link as header address
    } link_u;

    // oldest header carries this link, still compared
    localparam logic [15:0] LINK_END = 16'hffff;

    // token delimiter and end of input
    localparam forth_mem_pkg::byte_t CHAR_SPACE = 8'h20;
    localparam forth_mem_pkg::byte_t CHAR_NUL   = 8'h00;

    // finder states, the middle ones follow the header fields
    typedef enum logic [2:0] {
        ST_IDLE,        // waiting for en
        ST_SKIP,        // skip leading spaces, catch end of input
        ST_LINK_LO,     // link low byte arrives
        ST_LINK_HI,     // link high byte arrives
        ST_LEN,         // name length arrives
        ST_NAME,        // name byte fetch, then tib byte compare
        ST_DELIM,       // byte after the name must be space or nul
        ST_DONE         // result held while en stays high
    } finder_state_e;

endpackage : forth_dict_pkg

//--- src/forth_mem_pkg.sv
// forth memory package
// byte type and default sizing for the dictionary and tib memory

package forth_mem_pkg;

    // one memory byte, the unit of every ram access
    typedef logic [7:0] byte_t;

    // byte address width, 128 KiB of address space
    localparam int ADDR_WIDTH_DEF = 17;

    // full address space backed by ram by default
    localparam int RAM_DEPTH_DEF = 1 << ADDR_WIDTH_DEF;

endpackage : forth_mem_pkg
